/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sources.f --top-module tb_lenet_seq -o sim_lenet_seq
	./obj_dir/sim_lenet_seq | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* common/dma_ctrl_if.sv */
interface dma_ctrl_if;
    import lenet_pkg::*;

    // start is a single-cycle pulse, base and len are sampled with it
    logic              start;
    logic [ADDR_W-1:0] base;
    logic [LEN_W-1:0]  len;
    logic              done;

    modport ctrl (
        output start,
        output base,
        output len,
        input  done
    );

    modport dma (
        input  start,
        input  base,
        input  len,
        output done
    );

endinterface

/* common/lenet_pkg.sv */
package lenet_pkg;

    // Layer order of one inference run
    typedef enum logic [2:0] {
        CONV1 = 3'd0,
        CONV2 = 3'd1,
        FC1   = 3'd2,
        FC2   = 3'd3,
        FC3   = 3'd4
    } layer_e;

    // Start code seen by the compute core
    typedef enum logic [1:0] {
        CORE_NONE = 2'd0,
        CORE_CONV = 2'd1,
        CORE_FC   = 2'd2
    } core_mode_e;

    localparam int NUM_LAYERS = 5;

    // Shape field widths
    localparam int OFMAP_W    = 5;
    localparam int IFMAP_CH_W = 6;
    localparam int IN_NODE_W  = 9;
    localparam int OUT_NODE_W = 7;

    // External memory word address and bias transfer length
    localparam int ADDR_W = 16;
    localparam int LEN_W  = 8;

    typedef struct packed {
        core_mode_e              mode;
        logic [1:0]              nth;
        logic [OFMAP_W-1:0]      ofmap_size;
        logic [IFMAP_CH_W-1:0]   ifmap_ch;
        logic [IN_NODE_W-1:0]    in_nodes;
        logic [OUT_NODE_W-1:0]   out_nodes;
        logic [ADDR_W-1:0]       bias_base;
        logic [LEN_W-1:0]        bias_len;
    } layer_cfg_t;

    // Unused shape fields of a mode stay zero
    localparam layer_cfg_t LAYER_TABLE [NUM_LAYERS] = '{
        '{mode: CORE_CONV, nth: 2'd0, ofmap_size: 5'd28, ifmap_ch: 6'd1,
          in_nodes: 9'd0, out_nodes: 7'd0,
          bias_base: 16'h0000, bias_len: 8'd6},
        '{mode: CORE_CONV, nth: 2'd1, ofmap_size: 5'd10, ifmap_ch: 6'd6,
          in_nodes: 9'd0, out_nodes: 7'd0,
          bias_base: 16'h0100, bias_len: 8'd16},
        '{mode: CORE_FC, nth: 2'd0, ofmap_size: 5'd0, ifmap_ch: 6'd0,
          in_nodes: 9'd400, out_nodes: 7'd120,
          bias_base: 16'h0200, bias_len: 8'd120},
        '{mode: CORE_FC, nth: 2'd1, ofmap_size: 5'd0, ifmap_ch: 6'd0,
          in_nodes: 9'd120, out_nodes: 7'd84,
          bias_base: 16'h0300, bias_len: 8'd84},
        '{mode: CORE_FC, nth: 2'd2, ofmap_size: 5'd0, ifmap_ch: 6'd0,
          in_nodes: 9'd84, out_nodes: 7'd10,
          bias_base: 16'h0400, bias_len: 8'd10}
    };

endpackage

/* dma/dma_engine.sv */
module dma_engine #(
    parameter int BIAS_W    = 16,
    parameter int BUF_DEPTH = 128
) (
    input  logic                            clk,
    input  logic                            rst_n,

    dma_ctrl_if.dma                         ctrl,

    output logic                            mem_req_o,
    output logic [lenet_pkg::ADDR_W-1:0]    mem_addr_o,
    input  logic                            mem_rvalid_i,
    input  logic [BIAS_W-1:0]               mem_rdata_i,

    output logic                            buf_we_o,
    output logic [$clog2(BUF_DEPTH)-1:0]    buf_waddr_o,
    output logic [BIAS_W-1:0]               buf_wdata_o
);
    import lenet_pkg::*;

    localparam int BUF_AW = $clog2(BUF_DEPTH);

    logic              busy_q;
    logic              done_q;
    logic [LEN_W-1:0]  issue_left_q;
    logic [LEN_W-1:0]  recv_cnt_q;
    logic [LEN_W-1:0]  len_q;
    logic [ADDR_W-1:0] addr_q;
    logic              last_beat;

    // Reads are fired back to back, data is counted as it returns
    assign mem_req_o  = (issue_left_q != '0);
    assign mem_addr_o = addr_q;

    assign buf_we_o    = busy_q && mem_rvalid_i;
    assign buf_waddr_o = BUF_AW'(recv_cnt_q);
    assign buf_wdata_o = mem_rdata_i;

    assign last_beat = buf_we_o && (recv_cnt_q == len_q - LEN_W'(1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q       <= 1'b0;
            done_q       <= 1'b0;
            issue_left_q <= '0;
            recv_cnt_q   <= '0;
        end else begin
            done_q <= 1'b0;
            if (ctrl.start) begin
                busy_q       <= (ctrl.len != '0);
                issue_left_q <= ctrl.len;
                recv_cnt_q   <= '0;
                done_q       <= (ctrl.len == '0);
            end else begin
                if (mem_req_o) begin
                    issue_left_q <= issue_left_q - LEN_W'(1);
                end
                if (buf_we_o) begin
                    recv_cnt_q <= recv_cnt_q + LEN_W'(1);
                end
                if (last_beat) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.start) begin
            addr_q <= ctrl.base;
            len_q  <= ctrl.len;
        end else if (mem_req_o) begin
            addr_q <= addr_q + ADDR_W'(1);
        end
    end

    assign ctrl.done = done_q;

endmodule

/* hdl/bias_buffer.sv */
module bias_buffer #(
    parameter int BIAS_W    = 16,
    parameter int BUF_DEPTH = 128
) (
    input  logic                            clk,

    input  logic                            we_i,
    input  logic [$clog2(BUF_DEPTH)-1:0]    waddr_i,
    input  logic [BIAS_W-1:0]               wdata_i,

    input  logic [$clog2(BUF_DEPTH)-1:0]    raddr_i,
    output logic [BIAS_W-1:0]               rdata_o
);

    logic [BIAS_W-1:0] mem_q [BUF_DEPTH];

    // Read-before-write on a same-address collision
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
        rdata_o <= mem_q[raddr_i];
    end

endmodule

/* hdl/lenet_seq_top.sv */
module lenet_seq_top #(
    parameter int BIAS_W    = 16,
    parameter int BUF_DEPTH = 128
) (
    input  logic                                clk,
    input  logic                                rst_n,

    // Host
    input  logic                                start_i,
    output logic                                cnn_done_o,

    // External memory
    output logic                                mem_req_o,
    output logic [lenet_pkg::ADDR_W-1:0]        mem_addr_o,
    input  logic                                mem_rvalid_i,
    input  logic [BIAS_W-1:0]                   mem_rdata_i,

    // Compute core
    output lenet_pkg::core_mode_e               start_core_o,
    output logic [1:0]                          nth_o,
    output logic [lenet_pkg::OFMAP_W-1:0]       ofmap_size_o,
    output logic [lenet_pkg::IFMAP_CH_W-1:0]    ifmap_ch_o,
    output logic [lenet_pkg::IN_NODE_W-1:0]     in_node_num_o,
    output logic [lenet_pkg::OUT_NODE_W-1:0]    out_node_num_o,
    input  logic                                conv_done_i,
    input  logic                                fc_done_i,
    input  logic [$clog2(BUF_DEPTH)-1:0]        bias_raddr_i,
    output logic [BIAS_W-1:0]                   bias_rdata_o
);

    localparam int BUF_AW = $clog2(BUF_DEPTH);

    logic              buf_we;
    logic [BUF_AW-1:0] buf_waddr;
    logic [BIAS_W-1:0] buf_wdata;

    dma_ctrl_if dma_if ();

    layer_ctrl u_layer_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .conv_done_i    (conv_done_i),
        .fc_done_i      (fc_done_i),
        .dma            (dma_if.ctrl),
        .start_core_o   (start_core_o),
        .nth_o          (nth_o),
        .ofmap_size_o   (ofmap_size_o),
        .ifmap_ch_o     (ifmap_ch_o),
        .in_node_num_o  (in_node_num_o),
        .out_node_num_o (out_node_num_o),
        .cnn_done_o     (cnn_done_o)
    );

    dma_engine #(
        .BIAS_W    (BIAS_W),
        .BUF_DEPTH (BUF_DEPTH)
    ) u_dma_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (dma_if.dma),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .buf_we_o     (buf_we),
        .buf_waddr_o  (buf_waddr),
        .buf_wdata_o  (buf_wdata)
    );

    bias_buffer #(
        .BIAS_W    (BIAS_W),
        .BUF_DEPTH (BUF_DEPTH)
    ) u_bias_buffer (
        .clk     (clk),
        .we_i    (buf_we),
        .waddr_i (buf_waddr),
        .wdata_i (buf_wdata),
        .raddr_i (bias_raddr_i),
        .rdata_o (bias_rdata_o)
    );

endmodule

/* layer_ctrl/layer_ctrl.sv */
module layer_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                start_i,
    input  logic                                conv_done_i,
    input  logic                                fc_done_i,

    dma_ctrl_if.ctrl                            dma,

    output lenet_pkg::core_mode_e               start_core_o,
    output logic [1:0]                          nth_o,
    output logic [lenet_pkg::OFMAP_W-1:0]       ofmap_size_o,
    output logic [lenet_pkg::IFMAP_CH_W-1:0]    ifmap_ch_o,
    output logic [lenet_pkg::IN_NODE_W-1:0]     in_node_num_o,
    output logic [lenet_pkg::OUT_NODE_W-1:0]    out_node_num_o,

    output logic                                cnn_done_o
);
    import lenet_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_DMA  = 2'd1,
        S_RUN  = 2'd2,
        S_DONE = 2'd3
    } state_e;

    state_e     state_q;
    layer_e     layer_q;
    layer_cfg_t cfg;

    logic       dma_start_q;
    core_mode_e start_core_q;
    logic       cnn_done_q;
    logic       run_active;
    logic       core_done;

    assign cfg        = LAYER_TABLE[layer_q];
    assign run_active = (state_q == S_RUN);

    // Only the done strobe of the running datapath counts
    assign core_done = (cfg.mode == CORE_CONV) ? conv_done_i : fc_done_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= S_IDLE;
            layer_q      <= CONV1;
            dma_start_q  <= 1'b0;
            start_core_q <= CORE_NONE;
            cnn_done_q   <= 1'b0;
        end else begin
            dma_start_q  <= 1'b0;
            start_core_q <= CORE_NONE;
            cnn_done_q   <= 1'b0;

            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        // CONV1 bias is fetched before the first layer
                        layer_q     <= CONV1;
                        dma_start_q <= 1'b1;
                        state_q     <= S_DMA;
                    end
                end

                S_DMA: begin
                    if (dma.done) begin
                        start_core_q <= cfg.mode;
                        state_q      <= S_RUN;
                    end
                end

                S_RUN: begin
                    if (core_done) begin
                        if (layer_q == FC3) begin
                            cnn_done_q <= 1'b1;
                            state_q    <= S_DONE;
                        end else begin
                            layer_q     <= layer_e'(layer_q + 3'd1);
                            dma_start_q <= 1'b1;
                            state_q     <= S_DMA;
                        end
                    end
                end

                S_DONE: begin
                    state_q <= S_IDLE;
                end

                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // Bias request for the layer held in layer_q
    assign dma.start = dma_start_q;
    assign dma.base  = cfg.bias_base;
    assign dma.len   = cfg.bias_len;

    assign start_core_o = start_core_q;
    assign cnn_done_o   = cnn_done_q;

    // Shapes are levels for the whole run phase of a layer
    assign nth_o          = run_active ? cfg.nth        : '0;
    assign ofmap_size_o   = run_active ? cfg.ofmap_size : '0;
    assign ifmap_ch_o     = run_active ? cfg.ifmap_ch   : '0;
    assign in_node_num_o  = run_active ? cfg.in_nodes   : '0;
    assign out_node_num_o = run_active ? cfg.out_nodes  : '0;

endmodule

/* sources.f */
common/lenet_pkg.sv
common/dma_ctrl_if.sv
layer_ctrl/layer_ctrl.sv
dma/dma_engine.sv
hdl/bias_buffer.sv
hdl/lenet_seq_top.sv
tests/lenet_seq_properties.sv
tests/tb_lenet_seq.sv

/* tests/lenet_seq_properties.sv */
module lenet_seq_properties (
    input logic                  clk,
    input logic                  rst_n,
    input lenet_pkg::core_mode_e start_core_i,
    input logic                  dma_start_i,
    input logic                  dma_done_i,
    input logic                  cnn_done_i,
    input logic                  state_idle_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import lenet_pkg::*;

    int   fail_cnt = 0;
    logic xfer_active_q;

    // Open from a dma start until its done
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xfer_active_q <= 1'b0;
        end else if (dma_start_i) begin
            xfer_active_q <= 1'b1;
        end else if (dma_done_i) begin
            xfer_active_q <= 1'b0;
        end
    end

    a_core_start_single: assert property (@(posedge clk) disable iff (!rst_n)
        (start_core_i != CORE_NONE) |=> (start_core_i == CORE_NONE))
        else begin
            fail_cnt++;
            $error("core start active in two consecutive cycles");
        end

    a_dma_start_free: assert property (@(posedge clk) disable iff (!rst_n)
        dma_start_i |-> !xfer_active_q)
        else begin
            fail_cnt++;
            $error("dma start issued while a transfer is active");
        end

    a_done_to_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cnn_done_i |=> state_idle_i)
        else begin
            fail_cnt++;
            $error("sequencer not idle after network done");
        end

endmodule

bind layer_ctrl lenet_seq_properties i_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_core_i (start_core_o),
    .dma_start_i  (dma_start_q),
    .dma_done_i   (dma.done),
    .cnn_done_i   (cnn_done_o),
    .state_idle_i (state_q == S_IDLE)
);

/* tests/tb_lenet_seq.sv */
module tb_lenet_seq;
    timeunit 1ns;
    timeprecision 1ps;
    import lenet_pkg::*;

    localparam int BIAS_W      = 16;
    localparam int BUF_DEPTH   = 128;
    localparam int BUF_AW      = $clog2(BUF_DEPTH);
    localparam int NUM_RUNS    = 2;
    // Every bias word is fetched and read back once, plus latency and busy slack per layer
    localparam int RUN_WORST   = 2 * (6 + 16 + 120 + 84 + 10) + NUM_LAYERS * 60;
    localparam int CYCLE_LIMIT = 2 * NUM_RUNS * RUN_WORST;

    typedef struct packed {
        core_mode_e            mode;
        logic [1:0]            nth;
        logic [OFMAP_W-1:0]    ofmap;
        logic [IFMAP_CH_W-1:0] ch;
        logic [IN_NODE_W-1:0]  in_n;
        logic [OUT_NODE_W-1:0] out_n;
        logic [ADDR_W-1:0]     base;
        logic [LEN_W-1:0]      len;
    } exp_cfg_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  start_i;
    logic                  cnn_done_o;
    logic                  mem_req_o;
    logic [ADDR_W-1:0]     mem_addr_o;
    logic                  mem_rvalid_i = 1'b0;
    logic [BIAS_W-1:0]     mem_rdata_i = '0;
    core_mode_e            start_core_o;
    logic [1:0]            nth_o;
    logic [OFMAP_W-1:0]    ofmap_size_o;
    logic [IFMAP_CH_W-1:0] ifmap_ch_o;
    logic [IN_NODE_W-1:0]  in_node_num_o;
    logic [OUT_NODE_W-1:0] out_node_num_o;
    logic                  conv_done_i;
    logic                  fc_done_i;
    logic [BUF_AW-1:0]     bias_raddr_i;
    logic [BIAS_W-1:0]     bias_rdata_o;

    logic                  rd_en = 1'b0;
    logic                  rd_vld_q = 1'b0;
    logic [BUF_AW-1:0]     rd_addr_q;
    logic                  conv_done_q = 1'b0;
    logic                  fc_done_q = 1'b0;
    logic [ADDR_W-1:0]     mem_addr_q[$];
    int                    mem_due_q[$];
    int                    mem_due;
    logic [BIAS_W-1:0]     exp_word;
    exp_cfg_t              cur;
    bit                    in_run = 1'b0;
    int                    cycles = 0;
    int                    errors = 0;
    int                    step = 0;
    int                    req_cnt = 0;
    int                    done_cnt = 0;

    lenet_seq_top #(.BIAS_W(BIAS_W), .BUF_DEPTH(BUF_DEPTH)) i_dut (.*);

    always #10 clk = ~clk;

    function automatic logic [BIAS_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
        return BIAS_W'(addr ^ 16'h5A5A);
    endfunction

    // Expected shape and bias request of each layer step, in run order
    function automatic exp_cfg_t expected_cfg(input int layer);
        exp_cfg_t c;
        c = '0;
        case (layer)
            0: c = '{CORE_CONV, 2'd0, 5'd28, 6'd1, 9'd0, 7'd0, 16'h0000, 8'd6};
            1: c = '{CORE_CONV, 2'd1, 5'd10, 6'd6, 9'd0, 7'd0, 16'h0100, 8'd16};
            2: c = '{CORE_FC, 2'd0, 5'd0, 6'd0, 9'd400, 7'd120, 16'h0200, 8'd120};
            3: c = '{CORE_FC, 2'd1, 5'd0, 6'd0, 9'd120, 7'd84, 16'h0300, 8'd84};
            4: c = '{CORE_FC, 2'd2, 5'd0, 6'd0, 9'd84, 7'd10, 16'h0400, 8'd10};
            default: c = '0;
        endcase
        return c;
    endfunction

    task automatic report_mismatch(input string name, input int unsigned exp_v,
                                   input int unsigned act_v);
        $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, exp_v, act_v);
        errors++;
    endtask

    task automatic check_shapes();
        if (nth_o != cur.nth) begin
            report_mismatch("nth", 32'(cur.nth), 32'(nth_o));
        end
        if (ofmap_size_o != cur.ofmap) begin
            report_mismatch("ofmap size", 32'(cur.ofmap), 32'(ofmap_size_o));
        end
        if (ifmap_ch_o != cur.ch) begin
            report_mismatch("ifmap channels", 32'(cur.ch), 32'(ifmap_ch_o));
        end
        if (in_node_num_o != cur.in_n) begin
            report_mismatch("in nodes", 32'(cur.in_n), 32'(in_node_num_o));
        end
        if (out_node_num_o != cur.out_n) begin
            report_mismatch("out nodes", 32'(cur.out_n), 32'(out_node_num_o));
        end
    endtask

    task automatic finish_run(input bit timed_out);
        int asrt_fails;
        int total;
        asrt_fails = i_dut.u_layer_ctrl.i_props.fail_cnt;
        total      = errors + asrt_fails + int'(timed_out);
        if (!timed_out && done_cnt != NUM_RUNS) begin
            $display("ERROR: network done pulsed %0d times in %0d runs", done_cnt, NUM_RUNS);
            total++;
        end
        $display("Error counts: %0d check, %0d assertion, %0d total", errors, asrt_fails, total);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // Core model of one layer that reads back the bias and injects a wrong-type done
    task automatic run_layer(input int layer, input bit poke_start);
        exp_cfg_t e;
        int       busy;
        e = expected_cfg(layer);
        while (start_core_o == CORE_NONE) @(negedge clk);
        for (int a = 0; a < int'(e.len); a++) begin
            rd_en        = 1'b1;
            bias_raddr_i = BUF_AW'(a);
            @(negedge clk);
        end
        rd_en = 1'b0;
        if (e.mode == CORE_CONV) begin
            fc_done_i = 1'b1;
        end else begin
            conv_done_i = 1'b1;
        end
        @(negedge clk);
        fc_done_i   = 1'b0;
        conv_done_i = 1'b0;
        start_i     = poke_start;
        @(negedge clk);
        start_i = 1'b0;
        busy    = 5 + int'($urandom % 36);
        repeat (busy) @(negedge clk);
        if (e.mode == CORE_CONV) begin
            conv_done_i = 1'b1;
        end else begin
            fc_done_i = 1'b1;
        end
        @(negedge clk);
        conv_done_i = 1'b0;
        fc_done_i   = 1'b0;
    endtask

    // External memory that answers in order after 1 to 4 cycles
    always @(negedge clk) begin
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        if (mem_due_q.size() > 0 && mem_due_q[0] <= cycles) begin
            mem_rvalid_i = 1'b1;
            mem_rdata_i  = mem_word(mem_addr_q.pop_front());
            void'(mem_due_q.pop_front());
        end
        if (rst_n && mem_req_o) begin
            mem_due = cycles + 1 + int'($urandom % 4);
            if (mem_due_q.size() > 0 && mem_due <= mem_due_q[$]) begin
                mem_due = mem_due_q[$] + 1;
            end
            mem_due_q.push_back(mem_due);
            mem_addr_q.push_back(mem_addr_o);
        end
    end

    always @(posedge clk) begin
        rd_vld_q    <= rd_en;
        rd_addr_q   <= bias_raddr_i;
        conv_done_q <= conv_done_i;
        fc_done_q   <= fc_done_i;
    end

    always @(negedge clk) begin
        if (rst_n) begin
            cur = expected_cfg(step);
            if (in_run && ((cur.mode == CORE_CONV) ? conv_done_q : fc_done_q)) begin
                in_run = 1'b0;
                step++;
                cur = expected_cfg(step);
            end
            if (start_core_o != CORE_NONE) begin
                if (in_run || step >= NUM_LAYERS) begin
                    $display("ERROR: core start pulse while no layer was due (step %0d)", step);
                    errors++;
                end else begin
                    if (start_core_o != cur.mode) begin
                        report_mismatch("core mode", 32'(cur.mode), 32'(start_core_o));
                    end
                    if (req_cnt != int'(cur.len)) begin
                        report_mismatch("dma requests", 32'(cur.len), 32'(req_cnt));
                    end
                    check_shapes();
                    req_cnt = 0;
                    in_run  = 1'b1;
                end
            end else if (in_run) begin
                check_shapes();
                exp_word = mem_word(cur.base + ADDR_W'(rd_addr_q));
                if (rd_vld_q && bias_rdata_o != exp_word) begin
                    report_mismatch("bias read", 32'(exp_word), 32'(bias_rdata_o));
                end
            end else if ({nth_o, ofmap_size_o, ifmap_ch_o,
                          in_node_num_o, out_node_num_o} != '0) begin
                $display("ERROR: shape outputs are not zero outside a layer run");
                errors++;
            end
            if (mem_req_o) begin
                if (in_run) begin
                    $display("ERROR: memory request while a layer is running");
                    errors++;
                end else if (mem_addr_o != cur.base + ADDR_W'(req_cnt)) begin
                    report_mismatch("dma address", 32'(cur.base + ADDR_W'(req_cnt)),
                                    32'(mem_addr_o));
                end
                req_cnt++;
            end
            if (cnn_done_o) begin
                done_cnt++;
                if (step != NUM_LAYERS) begin
                    $display("ERROR: network done before FC3 finished (step %0d)", step);
                    errors++;
                end
                step = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("ERROR: timeout, the runs did not finish within %0d cycles", CYCLE_LIMIT);
            finish_run(1'b1);
        end
    end

    initial begin
        void'($urandom(83566));
        rst_n        = 1'b0;
        start_i      = 1'b0;
        conv_done_i  = 1'b0;
        fc_done_i    = 1'b0;
        bias_raddr_i = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        for (int run = 0; run < NUM_RUNS; run++) begin
            @(negedge clk);
            start_i = 1'b1;
            @(negedge clk);
            start_i = 1'b0;
            // A start strobe in the middle of the first run must be ignored
            for (int layer = 0; layer < NUM_LAYERS; layer++) begin
                run_layer(layer, run == 0 && layer == 1);
            end
            while (!cnn_done_o) @(negedge clk);
            repeat (4) @(negedge clk);
        end
        finish_run(1'b0);
    end

endmodule
